//--- flist.f
rtl/matrix_pkg.sv
rtl/cmd_byte_fifo.sv
rtl/cmd_dispatch.sv
rtl/cmd_write_pixel.sv
rtl/cmd_read_pixel.sv
rtl/framebuffer_ram.sv
rtl/matrix_cmd_top.sv
verif/matrix_checker.sv
verif/matrix_cmd_properties.sv
verif/tb_matrix_cmd.sv

//--- rtl/cmd_byte_fifo.sv
`timescale 1ns/100ps

module cmd_byte_fifo #(
    parameter int FIFO_DEPTH = matrix_pkg::DEF_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  logic [7:0] in_data,
    input  logic       pop,
    output logic       fifo_nonempty,
    output logic [7:0] fifo_data,
    output logic       in_credit
);
    localparam int PTR_BITS = FIFO_DEPTH > 1 ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [7:0]          mem [0:FIFO_DEPTH-1];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_pop;

    // pointers wrap at the depth, which need not be a power of two.
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] p);
        if (p == PTR_BITS'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign do_pop        = pop && fifo_nonempty;
    assign fifo_nonempty = (count != '0);
    assign fifo_data     = mem[rd_ptr];

    // the host never sends without a credit, so a push always finds a free slot.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            in_credit <= do_pop;
            if (in_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({in_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- rtl/cmd_dispatch.sv
`timescale 1ns/100ps

module cmd_dispatch (
    input  logic       clk,
    input  logic       reset,
    input  logic       fifo_nonempty,
    input  logic [7:0] fifo_data,
    output logic       pop,
    output logic [7:0] payload,
    output logic       payload_valid,
    output logic       wp_enable,
    output logic       rp_enable,
    input  logic       wp_want_byte,
    input  logic       rp_want_byte,
    input  logic       wp_done,
    input  logic       rp_done
);
    import matrix_pkg::*;

    localparam logic [1:0] ST_OPCODE = 2'd0;
    localparam logic [1:0] ST_WRITE  = 2'd1;
    localparam logic [1:0] ST_READ   = 2'd2;

    logic [1:0] state;

    // a handler that has all its bytes drops want_byte, which stops the pops
    // until its done pulse arrives.
    always_comb begin
        case (state)
            ST_OPCODE: pop = fifo_nonempty;
            ST_WRITE:  pop = fifo_nonempty && wp_want_byte;
            ST_READ:   pop = fifo_nonempty && rp_want_byte;
            default:   pop = 1'b0;
        endcase
    end

    assign payload       = fifo_data;
    assign payload_valid = pop && (state != ST_OPCODE);
    assign wp_enable     = payload_valid && (state == ST_WRITE);
    assign rp_enable     = payload_valid && (state == ST_READ);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_OPCODE;
        end else begin
            case (state)
                ST_OPCODE: begin
                    // any other opcode byte is simply consumed.
                    if (pop) begin
                        if (fifo_data == OP_WRITE_PIXEL) begin
                            state <= ST_WRITE;
                        end else if (fifo_data == OP_READ_PIXEL) begin
                            state <= ST_READ;
                        end
                    end
                end
                ST_WRITE: begin
                    if (wp_done) begin
                        state <= ST_OPCODE;
                    end
                end
                ST_READ: begin
                    if (rp_done) begin
                        state <= ST_OPCODE;
                    end
                end
                default: state <= ST_OPCODE;
            endcase
        end
    end

endmodule

//--- rtl/cmd_read_pixel.sv
`timescale 1ns/100ps

module cmd_read_pixel #(
    parameter int ROW_BITS        = matrix_pkg::DEF_ROW_BITS,
    parameter int COL_BITS        = matrix_pkg::DEF_COL_BITS,
    parameter int BYTES_PER_PIXEL = matrix_pkg::DEF_BYTES_PER_PIXEL,
    localparam int IDX_BITS       = BYTES_PER_PIXEL > 1 ? $clog2(BYTES_PER_PIXEL) : 1,
    localparam int ADDR_BITS      = ROW_BITS + COL_BITS + IDX_BITS
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [7:0]           payload,
    output logic                 want_byte,
    output logic [ADDR_BITS-1:0] ram_raddr,
    input  logic [7:0]           ram_rdata,
    input  logic                 reply_credit,
    output logic                 reply_valid,
    output logic [7:0]           reply_data,
    output logic                 done
);
    import matrix_pkg::*;

    localparam int COL_BYTES   = col_bytes(COL_BITS);
    localparam int CNT_BITS    = COL_BYTES > 1 ? $clog2(COL_BYTES) : 1;
    localparam int CREDIT_BITS = 8;

    localparam logic [2:0] ST_ROW  = 3'd0;
    localparam logic [2:0] ST_COL  = 3'd1;
    localparam logic [2:0] ST_READ = 3'd2;
    localparam logic [2:0] ST_LAST = 3'd3;
    localparam logic [2:0] ST_DONE = 3'd4;

    logic [2:0]             state;
    logic [ROW_BITS-1:0]    row;
    logic [COL_BITS-1:0]    col;
    logic [CNT_BITS-1:0]    col_cnt;
    logic [IDX_BITS-1:0]    idx;
    logic [CREDIT_BITS-1:0] credit_count;
    logic                   rd_issue;

    // a read is issued only against a held credit, and its byte leaves one
    // cycle later when the RAM output is valid.
    assign rd_issue   = (state == ST_READ) && (credit_count != '0);
    assign want_byte  = (state == ST_ROW) || (state == ST_COL);
    assign ram_raddr  = {row, col, idx};
    assign reply_data = ram_rdata;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_count <= '0;
            reply_valid  <= 1'b0;
        end else begin
            credit_count <= credit_count + CREDIT_BITS'(reply_credit)
                            - CREDIT_BITS'(rd_issue);
            reply_valid  <= rd_issue;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_ROW;
            row     <= '0;
            col     <= '0;
            col_cnt <= '0;
            idx     <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ST_ROW: begin
                    if (enable) begin
                        row     <= payload[ROW_BITS-1:0];
                        col_cnt <= '0;
                        state   <= ST_COL;
                    end
                end
                ST_COL: begin
                    if (enable) begin
                        col <= col | (COL_BITS'(payload) << (col_cnt * 8));
                        if (col_cnt == CNT_BITS'(COL_BYTES - 1)) begin
                            idx   <= IDX_BITS'(BYTES_PER_PIXEL - 1);
                            state <= ST_READ;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                ST_READ: begin
                    if (rd_issue) begin
                        if (idx == '0) begin
                            state <= ST_LAST;
                        end else begin
                            idx <= idx - 1'b1;
                        end
                    end
                end
                ST_LAST: begin
                    // the last reply byte is on the port in this cycle.
                    done  <= 1'b1;
                    state <= ST_DONE;
                end
                default: begin
                    row   <= '0;
                    col   <= '0;
                    state <= ST_ROW;
                end
            endcase
        end
    end

endmodule

//--- rtl/cmd_write_pixel.sv
`timescale 1ns/100ps

module cmd_write_pixel #(
    parameter int ROW_BITS        = matrix_pkg::DEF_ROW_BITS,
    parameter int COL_BITS        = matrix_pkg::DEF_COL_BITS,
    parameter int BYTES_PER_PIXEL = matrix_pkg::DEF_BYTES_PER_PIXEL,
    localparam int IDX_BITS       = BYTES_PER_PIXEL > 1 ? $clog2(BYTES_PER_PIXEL) : 1,
    localparam int ADDR_BITS      = ROW_BITS + COL_BITS + IDX_BITS
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enable,
    input  logic [7:0]           payload,
    output logic                 want_byte,
    output logic                 ram_wr,
    output logic [ADDR_BITS-1:0] ram_waddr,
    output logic [7:0]           ram_wdata,
    output logic                 done
);
    import matrix_pkg::*;

    localparam int COL_BYTES = col_bytes(COL_BITS);
    localparam int CNT_BITS  = COL_BYTES > 1 ? $clog2(COL_BYTES) : 1;

    localparam logic [1:0] ST_ROW  = 2'd0;
    localparam logic [1:0] ST_COL  = 2'd1;
    localparam logic [1:0] ST_DATA = 2'd2;
    localparam logic [1:0] ST_DONE = 2'd3;

    logic [1:0]          state;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] col;
    logic [CNT_BITS-1:0] col_cnt;
    logic [IDX_BITS-1:0] idx;

    assign want_byte = (state != ST_DONE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= ST_ROW;
            row     <= '0;
            col     <= '0;
            col_cnt <= '0;
            idx     <= '0;
            ram_wr  <= 1'b0;
            done    <= 1'b0;
        end else begin
            ram_wr <= 1'b0;
            done   <= 1'b0;
            case (state)
                ST_ROW: begin
                    if (enable) begin
                        row     <= payload[ROW_BITS-1:0];
                        col_cnt <= '0;
                        state   <= ST_COL;
                    end
                end
                ST_COL: begin
                    // column arrives least significant byte first.
                    if (enable) begin
                        col <= col | (COL_BITS'(payload) << (col_cnt * 8));
                        if (col_cnt == CNT_BITS'(COL_BYTES - 1)) begin
                            idx   <= IDX_BITS'(BYTES_PER_PIXEL - 1);
                            state <= ST_DATA;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (enable) begin
                        ram_wr <= 1'b1;
                        if (idx == '0) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            idx <= idx - 1'b1;
                        end
                    end
                end
                default: begin
                    row   <= '0;
                    col   <= '0;
                    state <= ST_ROW;
                end
            endcase
        end
    end

    // the first data byte goes to the highest byte index of the pixel.
    always_ff @(posedge clk) begin
        if (enable && state == ST_DATA) begin
            ram_waddr <= {row, col, idx};
            ram_wdata <= payload;
        end
    end

endmodule

//--- rtl/framebuffer_ram.sv
`timescale 1ns/100ps

module framebuffer_ram #(
    parameter int ROW_BITS        = matrix_pkg::DEF_ROW_BITS,
    parameter int COL_BITS        = matrix_pkg::DEF_COL_BITS,
    parameter int BYTES_PER_PIXEL = matrix_pkg::DEF_BYTES_PER_PIXEL,
    localparam int IDX_BITS       = BYTES_PER_PIXEL > 1 ? $clog2(BYTES_PER_PIXEL) : 1,
    localparam int ADDR_BITS      = ROW_BITS + COL_BITS + IDX_BITS
) (
    input  logic                 clk,
    input  logic                 wr,
    input  logic [ADDR_BITS-1:0] waddr,
    input  logic [7:0]           wdata,
    input  logic [ADDR_BITS-1:0] raddr,
    output logic [7:0]           rdata
);
    logic [7:0] mem [0:(2**ADDR_BITS)-1];

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read on every clock.
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

//--- rtl/matrix_cmd_top.sv
`timescale 1ns/100ps

module matrix_cmd_top #(
    parameter int ROW_BITS        = matrix_pkg::DEF_ROW_BITS,
    parameter int COL_BITS        = matrix_pkg::DEF_COL_BITS,
    parameter int BYTES_PER_PIXEL = matrix_pkg::DEF_BYTES_PER_PIXEL,
    parameter int FIFO_DEPTH      = matrix_pkg::DEF_FIFO_DEPTH
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  logic [7:0] in_data,
    output logic       in_credit,
    input  logic       reply_credit,
    output logic       reply_valid,
    output logic [7:0] reply_data
);
    localparam int IDX_BITS  = BYTES_PER_PIXEL > 1 ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam int ADDR_BITS = ROW_BITS + COL_BITS + IDX_BITS;

    logic                 fifo_nonempty;
    logic [7:0]           fifo_data;
    logic                 pop;
    logic [7:0]           payload;
    logic                 payload_valid;
    logic                 wp_enable;
    logic                 rp_enable;
    logic                 wp_want_byte;
    logic                 rp_want_byte;
    logic                 wp_done;
    logic                 rp_done;
    logic                 ram_wr;
    logic [ADDR_BITS-1:0] ram_waddr;
    logic [7:0]           ram_wdata;
    logic [ADDR_BITS-1:0] ram_raddr;
    logic [7:0]           ram_rdata;

    cmd_byte_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) u_fifo (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .pop          (pop),
        .fifo_nonempty(fifo_nonempty),
        .fifo_data    (fifo_data),
        .in_credit    (in_credit)
    );

    cmd_dispatch u_dispatch (
        .clk          (clk),
        .reset        (reset),
        .fifo_nonempty(fifo_nonempty),
        .fifo_data    (fifo_data),
        .pop          (pop),
        .payload      (payload),
        .payload_valid(payload_valid),
        .wp_enable    (wp_enable),
        .rp_enable    (rp_enable),
        .wp_want_byte (wp_want_byte),
        .rp_want_byte (rp_want_byte),
        .wp_done      (wp_done),
        .rp_done      (rp_done)
    );

    cmd_write_pixel #(
        .ROW_BITS       (ROW_BITS),
        .COL_BITS       (COL_BITS),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) u_write (
        .clk      (clk),
        .reset    (reset),
        .enable   (wp_enable),
        .payload  (payload),
        .want_byte(wp_want_byte),
        .ram_wr   (ram_wr),
        .ram_waddr(ram_waddr),
        .ram_wdata(ram_wdata),
        .done     (wp_done)
    );

    cmd_read_pixel #(
        .ROW_BITS       (ROW_BITS),
        .COL_BITS       (COL_BITS),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) u_read (
        .clk         (clk),
        .reset       (reset),
        .enable      (rp_enable),
        .payload     (payload),
        .want_byte   (rp_want_byte),
        .ram_raddr   (ram_raddr),
        .ram_rdata   (ram_rdata),
        .reply_credit(reply_credit),
        .reply_valid (reply_valid),
        .reply_data  (reply_data),
        .done        (rp_done)
    );

    framebuffer_ram #(
        .ROW_BITS       (ROW_BITS),
        .COL_BITS       (COL_BITS),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) u_ram (
        .clk  (clk),
        .wr   (ram_wr),
        .waddr(ram_waddr),
        .wdata(ram_wdata),
        .raddr(ram_raddr),
        .rdata(ram_rdata)
    );

endmodule

//--- rtl/matrix_pkg.sv
package matrix_pkg;

    // command opcodes on the host byte stream.
    localparam logic [7:0] OP_WRITE_PIXEL = 8'h01;
    localparam logic [7:0] OP_READ_PIXEL  = 8'h02;

    // default framebuffer geometry.
    localparam int DEF_ROW_BITS        = 5;
    localparam int DEF_COL_BITS        = 9;
    localparam int DEF_BYTES_PER_PIXEL = 3;

    // input FIFO depth, which is also the number of credits the host starts with.
    localparam int DEF_FIFO_DEPTH = 8;

    // number of whole bytes needed to carry a column address.
    function automatic int col_bytes(input int bits);
        return (bits + 7) / 8;
    endfunction

endpackage

//--- run.sh
#!/bin/bash
# Build and run the matrix command testbench with Verilator.
# The run passes only if the log holds the pass message and not the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_matrix_cmd -f flist.f -o sim_matrix \
    > build.log 2>&1 \
    && ./obj_dir/sim_matrix > sim.log 2>&1 \
    || echo "build or simulation did not complete, see build.log" >> sim.log

cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1
grep -q "PASS: all tests" sim.log || exit 1
exit 0

//--- verif/matrix_checker.sv
`timescale 1ns/100ps

module matrix_checker #(
    parameter int ROW_BITS        = matrix_pkg::DEF_ROW_BITS,
    parameter int COL_BITS        = matrix_pkg::DEF_COL_BITS,
    parameter int BYTES_PER_PIXEL = matrix_pkg::DEF_BYTES_PER_PIXEL
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       in_valid,
    input  logic [7:0] in_data,
    input  logic       reply_valid,
    input  logic [7:0] reply_data,
    output int         pending,
    output int         errors,
    output int         replies
);
    localparam int IDX_BITS  = BYTES_PER_PIXEL > 1 ? $clog2(BYTES_PER_PIXEL) : 1;
    localparam int COL_BYTES = (COL_BITS + 7) / 8;

    logic [7:0] model [int];
    logic [7:0] exp_q [$];
    int         mode;
    int         n;
    int         row;
    int         col;

    function automatic int pixel_addr(input int r, input int c, input int idx);
        return (((r << COL_BITS) | c) << IDX_BITS) | idx;
    endfunction

    // decodes the host stream in the order the DUT executes it.
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            mode    = 0;
            n       = 0;
            pending <= 0;
            errors  <= 0;
            replies <= 0;
        end else begin
            if (in_valid) begin
                if (mode == 0) begin
                    n   = 0;
                    col = 0;
                    if (in_data == matrix_pkg::OP_WRITE_PIXEL) mode = 1;
                    else if (in_data == matrix_pkg::OP_READ_PIXEL) mode = 2;
                end else begin
                    if (n == 0) begin
                        row = int'(in_data) % (1 << ROW_BITS);
                    end else if (n <= COL_BYTES) begin
                        col = (col | (int'(in_data) << (8 * (n - 1)))) % (1 << COL_BITS);
                    end else begin
                        model[pixel_addr(row, col, BYTES_PER_PIXEL - 1 - (n - 1 - COL_BYTES))]
                            = in_data;
                    end
                    n = n + 1;
                    if (mode == 2 && n == 1 + COL_BYTES) begin
                        for (int i = BYTES_PER_PIXEL - 1; i >= 0; i--) begin
                            if (model.exists(pixel_addr(row, col, i))) begin
                                exp_q.push_back(model[pixel_addr(row, col, i)]);
                            end else begin
                                exp_q.push_back(8'h00);
                            end
                        end
                        mode = 0;
                    end else if (mode == 1 && n == 1 + COL_BYTES + BYTES_PER_PIXEL) begin
                        mode = 0;
                    end
                end
            end
            if (reply_valid) begin
                replies <= replies + 1;
                if (exp_q.size() == 0) begin
                    $display("reply byte %h arrived at %0t with no read pending", reply_data,
                             $time);
                    errors <= errors + 1;
                end else if (exp_q[0] !== reply_data) begin
                    $display("FAIL %0t reply_data expected %h got %h", $time, exp_q[0],
                             reply_data);
                    errors <= errors + 1;
                end
                if (exp_q.size() != 0) begin
                    void'(exp_q.pop_front());
                end
            end
            pending <= exp_q.size();
        end
    end

endmodule

//--- verif/matrix_cmd_properties.sv
`timescale 1ns/100ps

module matrix_cmd_properties #(
    parameter int FIFO_DEPTH = matrix_pkg::DEF_FIFO_DEPTH
) (
    input logic clk,
    input logic reset,
    input logic in_valid,
    input logic in_credit,
    input logic pop,
    input logic fifo_nonempty,
    input logic reply_credit,
    input logic reply_valid,
    input logic ram_wr
);
    int occupancy;
    int reply_avail;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupancy   <= 0;
            reply_avail <= 0;
        end else begin
            occupancy   <= occupancy + int'(in_valid) - int'(pop && fifo_nonempty);
            reply_avail <= reply_avail + int'(reply_credit) - int'(reply_valid);
        end
    end

    fifo_bound: assert property (@(posedge clk) disable iff (reset) occupancy <= FIFO_DEPTH)
        else $error("input FIFO holds more than %0d bytes", FIFO_DEPTH);

    reply_needs_credit: assert property (@(posedge clk) disable iff (reset)
        reply_valid |-> reply_avail > 0)
        else $error("reply byte sent without a reply credit");

    quiet_in_reset: assert property (@(posedge clk) reset |-> !in_credit && !ram_wr)
        else $error("in_credit or the write strobe is high during reset");

endmodule

bind matrix_cmd_top matrix_cmd_properties #(.FIFO_DEPTH(FIFO_DEPTH)) i_props (
    .clk          (clk),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_credit    (in_credit),
    .pop          (pop),
    .fifo_nonempty(fifo_nonempty),
    .reply_credit (reply_credit),
    .reply_valid  (reply_valid),
    .ram_wr       (ram_wr)
);

//--- verif/tb_matrix_cmd.sv
`timescale 1ns/100ps

module tb_matrix_cmd;
    import matrix_pkg::*;

    localparam int BPP       = DEF_BYTES_PER_PIXEL;
    localparam int COL_BYTES = (DEF_COL_BITS + 7) / 8;
    localparam int K_WRITE   = 0;
    localparam int K_READ    = 1;
    localparam int K_BAD     = 2;

    typedef struct {
        int                   test;
        int                   kind;
        int                   row;
        int                   col;
        logic [BPP-1:0][7:0]  data;
    } cmd_t;

    logic       clk;
    logic       reset;
    logic       in_valid;
    logic [7:0] in_data;
    logic       in_credit;
    logic       reply_credit;
    logic       reply_valid;
    logic [7:0] reply_data;
    int         pending;
    int         chk_errors;
    int         replies;

    cmd_t       table_q [$];
    logic [7:0] tx_q [$];
    int         host_credits;
    int         in_credit_seen;
    int         granted;
    bit         grant_paused;
    int         tb_errors;
    int         failed_tests;

    matrix_cmd_top i_dut (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_data(in_data),
        .in_credit(in_credit), .reply_credit(reply_credit),
        .reply_valid(reply_valid), .reply_data(reply_data)
    );

    matrix_checker i_checker (
        .clk(clk), .reset(reset), .in_valid(in_valid), .in_data(in_data),
        .reply_valid(reply_valid), .reply_data(reply_data),
        .pending(pending), .errors(chk_errors), .replies(replies)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // host side, with credits on the input and grants on the reply stream.
    always @(negedge clk) begin
        if (!reset) begin
            host_credits   = host_credits + int'(in_credit);
            in_credit_seen = in_credit_seen + int'(in_credit);
            in_valid       = 1'b0;
            if (tx_q.size() > 0 && host_credits > 0 && $urandom_range(3) != 0) begin
                in_data      = tx_q.pop_front();
                in_valid     = 1'b1;
                host_credits = host_credits - 1;
            end
            reply_credit = 1'b0;
            if (!grant_paused && granted - replies < pending) begin
                reply_credit = 1'b1;
                granted      = granted + 1;
            end
        end
    end

    task automatic add(input int test, input int kind, input int row, input int col,
                       input logic [BPP-1:0][7:0] data);
        cmd_t c;
        c.test = test;
        c.kind = kind;
        c.row  = row;
        c.col  = col;
        c.data = data;
        table_q.push_back(c);
    endtask

    task automatic build_table();
        add(1, K_WRITE, 3, 10, 24'h112233);
        add(1, K_READ,  3, 10, 24'h0);
        add(2, K_WRITE, 3, 11, 24'h445566);
        add(2, K_WRITE, 4, 10, 24'h778899);
        add(2, K_WRITE, 3, 10, 24'ha1a2a3);
        add(2, K_READ,  3, 10, 24'h0);
        add(2, K_READ,  3, 11, 24'h0);
        add(2, K_READ,  4, 10, 24'h0);
        add(2, K_READ,  2, 10, 24'h0);
        add(3, K_WRITE, 5, 300, 24'hc0c1c2);
        add(3, K_WRITE, 5, 44, 24'hd0d1d2);
        add(3, K_WRITE, 5, 511, 24'he0e1e2);
        // column 256 lands on the pixel of column 300 if the column bytes are taken in the
        // wrong order.
        add(3, K_WRITE, 5, 256, 24'hb0b1b2);
        add(3, K_READ,  5, 300, 24'h0);
        add(3, K_READ,  5, 44, 24'h0);
        add(3, K_READ,  5, 511, 24'h0);
        add(3, K_READ,  5, 256, 24'h0);
        add(4, K_BAD,   0, 0, 24'h00007e);
        add(4, K_WRITE, 1, 1, 24'h5a6b7c);
        add(4, K_BAD,   0, 0, 24'h0000ff);
        add(4, K_READ,  1, 1, 24'h0);
        add(5, K_READ,  3, 10, 24'h0);
        add(5, K_READ,  5, 300, 24'h0);
        add(5, K_WRITE, 6, 7, 24'h313233);
        add(5, K_READ,  6, 7, 24'h0);
        add(5, K_WRITE, 3, 10, 24'h414243);
        add(5, K_READ,  3, 10, 24'h0);
    endtask

    // turns the table rows of one test into bytes for the host driver.
    task automatic queue_test(input int test);
        foreach (table_q[i]) begin
            if (table_q[i].test == test) begin
                if (table_q[i].kind == K_BAD) begin
                    tx_q.push_back(table_q[i].data[0]);
                end else begin
                    tx_q.push_back(table_q[i].kind == K_WRITE ? OP_WRITE_PIXEL : OP_READ_PIXEL);
                    tx_q.push_back(8'(table_q[i].row));
                    for (int k = 0; k < COL_BYTES; k++) begin
                        tx_q.push_back(8'(table_q[i].col >> (8 * k)));
                    end
                    if (table_q[i].kind == K_WRITE) begin
                        for (int k = 0; k < BPP; k++) begin
                            tx_q.push_back(table_q[i].data[BPP-1-k]);
                        end
                    end
                end
            end
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("FAIL: see errors above");
        $finish;
    endtask

    // every queued byte has been sent, taken by the DUT and answered.
    function automatic bit drained();
        return tx_q.size() == 0 && pending == 0 && host_credits == DEF_FIFO_DEPTH;
    endfunction

    task automatic wait_drained();
        int n;
        n = 0;
        while (!drained() && n <= 3000) begin
            @(posedge clk);
            n = n + 1;
        end
        if (!drained()) begin
            abort_run("timeout: the DUT did not finish the queued commands");
        end else begin
            repeat (4) @(posedge clk);
        end
    endtask

    // the host runs out of credits once the input FIFO is full.
    task automatic wait_input_full();
        int n;
        n = 0;
        while (host_credits != 0 && n <= 1000) begin
            @(posedge clk);
            n = n + 1;
        end
        if (host_credits != 0) begin
            abort_run("timeout: the input FIFO did not fill with reply credits held back");
        end
    endtask

    task automatic report_test(input int test, input int errs_before);
        int e;
        e = tb_errors + chk_errors - errs_before;
        if (e != 0) begin
            failed_tests = failed_tests + 1;
        end
        $display("test %0d: %s, %0d errors", test, e == 0 ? "ok" : "failed", e);
    endtask

    initial begin
        int errs_before;
        int replies_mark;
        int credit_mark;
        int granted_mark;
        void'($urandom(32'h646c));
        reset          = 1'b1;
        in_valid       = 1'b0;
        in_data        = 8'h00;
        reply_credit   = 1'b0;
        host_credits   = DEF_FIFO_DEPTH;
        in_credit_seen = 0;
        granted        = 0;
        grant_paused   = 1'b0;
        tb_errors      = 0;
        failed_tests   = 0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        for (int t = 1; t <= 4; t++) begin
            errs_before = tb_errors + chk_errors;
            queue_test(t);
            wait_drained();
            report_test(t, errs_before);
        end

        // back-pressure with the reply credits held back.
        errs_before  = tb_errors + chk_errors;
        grant_paused = 1'b1;
        replies_mark = replies;
        granted_mark = granted;
        queue_test(5);
        wait_input_full();
        credit_mark = in_credit_seen;
        repeat (20) @(posedge clk);
        if (replies != replies_mark) begin
            $display("reply bytes appeared while no reply credits were granted");
            tb_errors = tb_errors + 1;
        end
        if (in_credit_seen != credit_mark || host_credits != 0) begin
            $display("in_credit kept returning credits while the input FIFO was full");
            tb_errors = tb_errors + 1;
        end
        grant_paused = 1'b0;
        wait_drained();
        if (replies - replies_mark != granted - granted_mark) begin
            $display("%0d reply bytes arrived for %0d granted credits",
                     replies - replies_mark, granted - granted_mark);
            tb_errors = tb_errors + 1;
        end
        report_test(5, errs_before);

        $display("5 tests, %0d failed, %0d errors", failed_tests, tb_errors + chk_errors);
        if (tb_errors + chk_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
